// File: design/bcam_pkg.sv
// binary CAM shared definitions

package bcam_pkg;

    // geometry of the vlan map table
    localparam int KEY_BITS      = 12;
    localparam int VALUE_BITS    = 12;
    localparam int MAX_ENTRIES   = 32;
    localparam int ENTRY_ID_BITS = $clog2(MAX_ENTRIES);

    // register window
    localparam int REG_ADDR_BITS = 8;
    localparam int REG_DATA_BITS = 32;

    localparam logic [REG_ADDR_BITS-1:0] ADDR_CAM_CTRL         = 8'h00;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_CAM_ENTRY_ID     = 8'h01;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_CAM_LOOKUP_COUNT = 8'h03;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_CAM_HIT_COUNT    = 8'h04;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_CAM_MISS_COUNT   = 8'h05;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_CAM_DATA0        = 8'h10;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_CAM_DATA1        = 8'h11;

    // CTRL bit positions
    localparam int CTRL_RD_BIT     = 0;
    localparam int CTRL_WR_BIT     = 1;
    localparam int CTRL_RST_BIT    = 2;
    localparam int CTRL_IN_USE_BIT = 31;

    typedef logic [KEY_BITS-1:0]   cam_key_t;
    // action id in 1:0, ingress port in 11:2
    typedef logic [VALUE_BITS-1:0] cam_value_t;

    typedef struct packed {
        logic                     wr;
        logic                     rd;
        logic [ENTRY_ID_BITS-1:0] index;
        cam_key_t                 key;
        cam_value_t               value;
        logic                     in_use;
    } cam_cmd_t;

    typedef struct packed {
        logic       in_use;
        cam_key_t   key;
        cam_value_t value;
    } cam_entry_t;

    typedef struct packed {
        logic                              valid;
        logic [MAX_ENTRIES-1:0]            hits;
        cam_value_t [MAX_ENTRIES-1:0]      values;
    } cam_match_t;

endpackage

// File: design/bcam_reg_decode.sv
// CAM register window
`timescale 1ns/10ps

module bcam_reg_decode
    import bcam_pkg::*;
#(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                     core_clk_ifc,
    input  logic                     rst_n,
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  logic [REG_ADDR_BITS-1:0] reg_addr,
    input  logic [REG_DATA_BITS-1:0] reg_wdata,
    input  cam_entry_t               rd_entry,
    input  logic                     rd_entry_valid,
    input  logic [REG_DATA_BITS-1:0] lookup_count,
    input  logic [REG_DATA_BITS-1:0] hit_count,
    input  logic [REG_DATA_BITS-1:0] miss_count,
    output logic [REG_DATA_BITS-1:0] reg_rdata,
    output logic                     reg_rdata_valid,
    output cam_cmd_t                 cam_cmd,
    output logic                     counter_clear
);

    logic [ENTRY_ID_BITS-1:0] entry_id;
    cam_key_t                 data0;
    cam_value_t               data1;
    logic                     ctrl_rd;
    logic                     ctrl_wr;
    logic                     ctrl_in_use;
    logic                     ctrl_write;
    logic [REG_DATA_BITS-1:0] ctrl_word;
    logic [REG_DATA_BITS-1:0] rdata_next;

    assign ctrl_write = reg_wr && (reg_addr == ADDR_CAM_CTRL);

    //////////////////////////////////////////////////////////////////////
    // control flags and entry commands

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            entry_id      <= '0;
            ctrl_rd       <= 1'b0;
            ctrl_wr       <= 1'b0;
            ctrl_in_use   <= 1'b0;
            cam_cmd       <= '0;
            counter_clear <= 1'b0;
        end else begin
            // strobes last one cycle
            cam_cmd.wr    <= 1'b0;
            cam_cmd.rd    <= 1'b0;
            counter_clear <= 1'b0;

            if (reg_wr && (reg_addr == ADDR_CAM_ENTRY_ID)) begin
                entry_id <= reg_wdata[ENTRY_ID_BITS-1:0];
            end
            // store done, WR drops
            if (cam_cmd.wr) begin
                ctrl_wr <= 1'b0;
            end
            if (rd_entry_valid) begin
                ctrl_rd     <= 1'b0;
                ctrl_in_use <= rd_entry.in_use;
            end

            if (ctrl_write) begin
                ctrl_in_use   <= reg_wdata[CTRL_IN_USE_BIT];
                counter_clear <= reg_wdata[CTRL_RST_BIT];
                cam_cmd.index  <= entry_id;
                cam_cmd.key    <= data0;
                cam_cmd.value  <= data1;
                cam_cmd.in_use <= reg_wdata[CTRL_IN_USE_BIT];
                // write wins over read
                if (reg_wdata[CTRL_WR_BIT]) begin
                    ctrl_wr    <= 1'b1;
                    cam_cmd.wr <= 1'b1;
                end else if (reg_wdata[CTRL_RD_BIT]) begin
                    ctrl_rd    <= 1'b1;
                    cam_cmd.rd <= 1'b1;
                end
            end
        end
    end

    // data words, loaded by software or by read-back
    always_ff @(posedge core_clk_ifc) begin
        if (rd_entry_valid) begin
            data0 <= rd_entry.key;
            data1 <= rd_entry.value;
        end else begin
            if (reg_wr && (reg_addr == ADDR_CAM_DATA0)) begin
                data0 <= reg_wdata[KEY_BITS-1:0];
            end
            if (reg_wr && (reg_addr == ADDR_CAM_DATA1)) begin
                data1 <= reg_wdata[VALUE_BITS-1:0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read-data mux

    always_comb begin
        ctrl_word                  = '0;
        ctrl_word[CTRL_RD_BIT]     = ctrl_rd;
        ctrl_word[CTRL_WR_BIT]     = ctrl_wr;
        ctrl_word[CTRL_RST_BIT]    = counter_clear;
        ctrl_word[CTRL_IN_USE_BIT] = ctrl_in_use;

        case (reg_addr)
            ADDR_CAM_CTRL:         rdata_next = ctrl_word;
            ADDR_CAM_ENTRY_ID:     rdata_next = REG_DATA_BITS'(entry_id);
            ADDR_CAM_LOOKUP_COUNT: rdata_next = lookup_count;
            ADDR_CAM_HIT_COUNT:    rdata_next = hit_count;
            ADDR_CAM_MISS_COUNT:   rdata_next = miss_count;
            ADDR_CAM_DATA0:        rdata_next = REG_DATA_BITS'(data0);
            ADDR_CAM_DATA1:        rdata_next = REG_DATA_BITS'(data1);
            default:               rdata_next = '0;
        endcase
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            reg_rdata_valid <= 1'b0;
        end else begin
            reg_rdata_valid <= reg_rd;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (reg_rd) begin
            reg_rdata <= rdata_next;
        end
    end

    // entry index must address a real slot in the store
    a_entry_id_range: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        (cam_cmd.wr || cam_cmd.rd) |-> (int'(cam_cmd.index) < NUM_ENTRIES))
        else $error("entry command with ENTRY_ID %0d out of range", cam_cmd.index);

endmodule

// File: design/bcam_entry_store.sv
// CAM entry storage and key match
`timescale 1ns/10ps

module bcam_entry_store
    import bcam_pkg::*;
#(
    parameter int NUM_ENTRIES = 32
) (
    input  logic       core_clk_ifc,
    input  logic       rst_n,
    input  cam_cmd_t   cam_cmd,
    input  logic       lookup_req,
    input  cam_key_t   lookup_key,
    output cam_entry_t rd_entry,
    output logic       rd_entry_valid,
    output cam_match_t match
);

    localparam int IDX_BITS = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    cam_entry_t                   entries [NUM_ENTRIES];
    logic [IDX_BITS-1:0]          cmd_idx;
    logic [MAX_ENTRIES-1:0]       hits;
    cam_value_t [MAX_ENTRIES-1:0] values;

    assign cmd_idx = cam_cmd.index[IDX_BITS-1:0];

    //////////////////////////////////////////////////////////////////////
    // entry writes

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            // all entries start unused
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entries[i].in_use <= 1'b0;
            end
        end else if (cam_cmd.wr) begin
            entries[cmd_idx].in_use <= cam_cmd.in_use;
            entries[cmd_idx].key    <= cam_cmd.key;
            entries[cmd_idx].value  <= cam_cmd.value;
        end
    end

    // read-back answered in the command cycle
    assign rd_entry       = entries[cmd_idx];
    assign rd_entry_valid = cam_cmd.rd;

    //////////////////////////////////////////////////////////////////////
    // parallel exact match

    always_comb begin
        hits   = '0;
        values = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            // unused entries never match
            hits[i]   = entries[i].in_use && (entries[i].key == lookup_key);
            values[i] = entries[i].value;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        match.hits   <= hits;
        match.values <= values;
        if (!rst_n) begin
            match.valid <= 1'b0;
        end else begin
            match.valid <= lookup_req;
        end
    end

    // the decoder never issues both commands at once
    a_cmd_exclusive: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        !(cam_cmd.wr && cam_cmd.rd))
        else $error("write and read entry commands in the same cycle");

endmodule

// File: design/bcam_lookup_result.sv
// CAM lookup result and counters
`timescale 1ns/10ps

module bcam_lookup_result
    import bcam_pkg::*;
#(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                     core_clk_ifc,
    input  logic                     rst_n,
    input  cam_match_t               match,
    input  logic                     counter_clear,
    output logic                     result_valid,
    output logic                     result_hit,
    output cam_value_t               result_value,
    output logic [REG_DATA_BITS-1:0] lookup_count,
    output logic [REG_DATA_BITS-1:0] hit_count,
    output logic [REG_DATA_BITS-1:0] miss_count
);

    logic       sel_hit;
    cam_value_t sel_value;

    //////////////////////////////////////////////////////////////////////
    // lowest index wins

    always_comb begin
        sel_hit   = 1'b0;
        sel_value = '0;
        // walk downward so the lowest match is taken last
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (match.valid && match.hits[i]) begin
                sel_hit   = 1'b1;
                sel_value = match.values[i];
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result_hit   <= 1'b0;
        end else begin
            result_valid <= match.valid;
            result_hit   <= sel_hit;
        end
    end

    // zero on a miss
    always_ff @(posedge core_clk_ifc) begin
        result_value <= sel_value;
    end

    //////////////////////////////////////////////////////////////////////
    // statistics, free running and wrapping

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n || counter_clear) begin
            lookup_count <= '0;
            hit_count    <= '0;
            miss_count   <= '0;
        end else if (result_valid) begin
            lookup_count <= lookup_count + 1'b1;
            if (result_hit) begin
                hit_count <= hit_count + 1'b1;
            end else begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    a_hit_needs_valid: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        result_hit |-> result_valid)
        else $error("result_hit without result_valid");

endmodule

// File: design/bcam_top.sv
// binary CAM top level
`timescale 1ns/10ps

module bcam_top
    import bcam_pkg::*;
#(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                     core_clk_ifc,
    input  logic                     rst_n,
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  logic [REG_ADDR_BITS-1:0] reg_addr,
    input  logic [REG_DATA_BITS-1:0] reg_wdata,
    input  logic                     lookup_req,
    input  cam_key_t                 lookup_key,
    output logic [REG_DATA_BITS-1:0] reg_rdata,
    output logic                     reg_rdata_valid,
    output logic                     result_valid,
    output logic                     result_hit,
    output cam_value_t               result_value
);

    cam_cmd_t                 cam_cmd;
    cam_entry_t               rd_entry;
    logic                     rd_entry_valid;
    cam_match_t               match;
    logic                     counter_clear;
    logic [REG_DATA_BITS-1:0] lookup_count;
    logic [REG_DATA_BITS-1:0] hit_count;
    logic [REG_DATA_BITS-1:0] miss_count;

    bcam_reg_decode #(
        .NUM_ENTRIES     ( NUM_ENTRIES     )
    ) i_bcam_reg_decode (
        .core_clk_ifc    ( core_clk_ifc    ),
        .rst_n           ( rst_n           ),
        .reg_wr          ( reg_wr          ),
        .reg_rd          ( reg_rd          ),
        .reg_addr        ( reg_addr        ),
        .reg_wdata       ( reg_wdata       ),
        .rd_entry        ( rd_entry        ),
        .rd_entry_valid  ( rd_entry_valid  ),
        .lookup_count    ( lookup_count    ),
        .hit_count       ( hit_count       ),
        .miss_count      ( miss_count      ),
        .reg_rdata       ( reg_rdata       ),
        .reg_rdata_valid ( reg_rdata_valid ),
        .cam_cmd         ( cam_cmd         ),
        .counter_clear   ( counter_clear   )
    );

    bcam_entry_store #(
        .NUM_ENTRIES    ( NUM_ENTRIES    )
    ) i_bcam_entry_store (
        .core_clk_ifc   ( core_clk_ifc   ),
        .rst_n          ( rst_n          ),
        .cam_cmd        ( cam_cmd        ),
        .lookup_req     ( lookup_req     ),
        .lookup_key     ( lookup_key     ),
        .rd_entry       ( rd_entry       ),
        .rd_entry_valid ( rd_entry_valid ),
        .match          ( match          )
    );

    bcam_lookup_result #(
        .NUM_ENTRIES   ( NUM_ENTRIES   )
    ) i_bcam_lookup_result (
        .core_clk_ifc  ( core_clk_ifc  ),
        .rst_n         ( rst_n         ),
        .match         ( match         ),
        .counter_clear ( counter_clear ),
        .result_valid  ( result_valid  ),
        .result_hit    ( result_hit    ),
        .result_value  ( result_value  ),
        .lookup_count  ( lookup_count  ),
        .hit_count     ( hit_count     ),
        .miss_count    ( miss_count    )
    );

endmodule

// File: sim/bcam_clk_gen.sv
// testbench clock and reset
`timescale 1ns/10ps

module bcam_clk_gen #(
    parameter int HALF_PERIOD_NS = 2,
    parameter int RESET_CYCLES   = 16
) (
    output logic core_clk_ifc,
    output logic rst_n
);

    initial begin
        core_clk_ifc = 1'b0;
        forever #(HALF_PERIOD_NS) core_clk_ifc = ~core_clk_ifc;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        rst_n = 1'b1;
    end

endmodule

// File: sim/bcam_tb.sv
// binary CAM testbench
`timescale 1ns/10ps

module bcam_tb
    import bcam_pkg::*;
();

    localparam int NUM_ENTRIES   = 32;
    localparam int PROG_ENTRIES  = 8;
    localparam int MISS_KEYS     = 6;
    localparam int PIPE_LOOKUPS  = 40;
    // data, value, index and control writes plus two polls
    localparam int PROG_ACCESSES = 6;
    localparam int PLANNED_OPS   = 7 + PROG_ENTRIES * (PROG_ACCESSES + 1) + MISS_KEYS
                                 + PROG_ACCESSES + 1 + 2 * (PROG_ACCESSES + 1)
                                 + PIPE_LOOKUPS + 7 + PROG_ENTRIES * 5;

    typedef struct packed {
        logic                     rd;
        logic [REG_DATA_BITS-1:0] data;
    } read_exp_t;

    typedef struct packed {
        logic       req;
        logic       hit;
        cam_value_t value;
    } lookup_exp_t;

    logic                     core_clk_ifc;
    logic                     rst_n;
    logic                     reg_wr;
    logic                     reg_rd;
    logic [REG_ADDR_BITS-1:0] reg_addr;
    logic [REG_DATA_BITS-1:0] reg_wdata;
    logic                     lookup_req;
    cam_key_t                 lookup_key;
    logic [REG_DATA_BITS-1:0] reg_rdata;
    logic                     reg_rdata_valid;
    logic                     result_valid;
    logic                     result_hit;
    cam_value_t               result_value;

    // reference model state
    cam_entry_t               model [NUM_ENTRIES];
    logic [REG_DATA_BITS-1:0] model_hits;
    logic [REG_DATA_BITS-1:0] model_misses;
    logic                     model_ctrl_in_use;
    int                       slots [PROG_ENTRIES];
    logic [15:0]              lfsr;
    int                       cycle    = 0;
    int                       wr_edge  = -10;
    int                       rd_edge  = -10;
    int                       rst_edge = -10;

    // expectations, delayed to line up with the DUT outputs
    read_exp_t                exp_read      = '0;
    read_exp_t                exp_read_d1   = '0;
    lookup_exp_t              exp_lookup    = '0;
    lookup_exp_t              exp_lookup_d1 = '0;
    lookup_exp_t              exp_lookup_d2 = '0;

    bcam_clk_gen i_bcam_clk_gen (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        )
    );

    bcam_top #(
        .NUM_ENTRIES     ( NUM_ENTRIES     )
    ) i_bcam_top (
        .core_clk_ifc    ( core_clk_ifc    ),
        .rst_n           ( rst_n           ),
        .reg_wr          ( reg_wr          ),
        .reg_rd          ( reg_rd          ),
        .reg_addr        ( reg_addr        ),
        .reg_wdata       ( reg_wdata       ),
        .lookup_req      ( lookup_req      ),
        .lookup_key      ( lookup_key      ),
        .reg_rdata       ( reg_rdata       ),
        .reg_rdata_valid ( reg_rdata_valid ),
        .result_valid    ( result_valid    ),
        .result_hit      ( result_hit      ),
        .result_value    ( result_value    )
    );

    always @(posedge core_clk_ifc) begin
        cycle         <= cycle + 1;
        exp_read_d1   <= exp_read;
        exp_lookup_d1 <= exp_lookup;
        exp_lookup_d2 <= exp_lookup_d1;
    end

    //////////////////////////////////////////////////////////////////////
    // checks against the model

    a_read_valid: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        reg_rdata_valid == exp_read_d1.rd)
        else stop_with_failure($sformatf("Error at time %0t: reg_rdata_valid %b, expected %b",
            $time, $sampled(reg_rdata_valid), $sampled(exp_read_d1.rd)));

    a_read_data: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        reg_rdata_valid |-> (reg_rdata == exp_read_d1.data))
        else stop_with_failure($sformatf("Error at time %0t: read data %h, expected %h",
            $time, $sampled(reg_rdata), $sampled(exp_read_d1.data)));

    a_result_valid: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        result_valid == exp_lookup_d2.req)
        else stop_with_failure($sformatf("Error at time %0t: result_valid %b, expected %b",
            $time, $sampled(result_valid), $sampled(exp_lookup_d2.req)));

    a_result_data: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        result_valid |-> (result_hit == exp_lookup_d2.hit
                          && result_value == exp_lookup_d2.value))
        else stop_with_failure($sformatf("Error at time %0t: hit %b value %h, expected %b %h",
            $time, $sampled(result_hit), $sampled(result_value),
            $sampled(exp_lookup_d2.hit), $sampled(exp_lookup_d2.value)));

    initial begin
        repeat (PLANNED_OPS * 10) @(posedge core_clk_ifc);
        stop_with_failure($sformatf("timeout: tests not done after %0d cycles",
            PLANNED_OPS * 10));
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // 16 bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // first in-use entry with an equal key wins
    function automatic void model_lookup(input cam_key_t key, output logic hit,
                                         output cam_value_t value);
        hit   = 1'b0;
        value = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!hit && model[i].in_use && model[i].key == key) begin
                hit   = 1'b1;
                value = model[i].value;
            end
        end
    endfunction

    // strobe bits read back as 1 only on the edge right after the CTRL write
    function automatic logic [REG_DATA_BITS-1:0] ctrl_expect(input int read_edge);
        logic [REG_DATA_BITS-1:0] w;
        w                  = '0;
        w[CTRL_RD_BIT]     = (read_edge == rd_edge + 1);
        w[CTRL_WR_BIT]     = (read_edge == wr_edge + 1);
        w[CTRL_RST_BIT]    = (read_edge == rst_edge + 1);
        w[CTRL_IN_USE_BIT] = model_ctrl_in_use;
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // bus tasks, each starts and ends on a falling edge

    task automatic idle(input int n);
        repeat (n) @(negedge core_clk_ifc);
    endtask

    task automatic reg_write(input logic [REG_ADDR_BITS-1:0] addr,
                             input logic [REG_DATA_BITS-1:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        if (addr == ADDR_CAM_CTRL) begin
            model_ctrl_in_use = data[CTRL_IN_USE_BIT];
            if (data[CTRL_WR_BIT]) begin
                wr_edge = cycle + 1;
            end else if (data[CTRL_RD_BIT]) begin
                rd_edge = cycle + 1;
            end
            if (data[CTRL_RST_BIT]) begin
                rst_edge     = cycle + 1;
                model_hits   = '0;
                model_misses = '0;
            end
        end
        @(negedge core_clk_ifc);
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input logic [REG_ADDR_BITS-1:0] addr,
                            input logic [REG_DATA_BITS-1:0] expected,
                            output logic [REG_DATA_BITS-1:0] data);
        reg_rd   = 1'b1;
        reg_addr = addr;
        exp_read = '{rd: 1'b1, data: expected};
        @(negedge core_clk_ifc);
        reg_rd      = 1'b0;
        exp_read.rd = 1'b0;
        while (!reg_rdata_valid) begin
            @(negedge core_clk_ifc);
        end
        data = reg_rdata;
    endtask

    task automatic lookup(input cam_key_t key);
        logic       hit;
        cam_value_t value;
        model_lookup(key, hit, value);
        lookup_req = 1'b1;
        lookup_key = key;
        exp_lookup = '{req: 1'b1, hit: hit, value: value};
        if (hit) begin
            model_hits = model_hits + 1;
        end else begin
            model_misses = model_misses + 1;
        end
        @(negedge core_clk_ifc);
        lookup_req     = 1'b0;
        exp_lookup.req = 1'b0;
    endtask

    task automatic program_entry(input int slot, input cam_key_t key,
                                 input cam_value_t value, input logic in_use);
        logic [REG_DATA_BITS-1:0] ctrl;
        logic [REG_DATA_BITS-1:0] data;
        ctrl                  = '0;
        ctrl[CTRL_WR_BIT]     = 1'b1;
        ctrl[CTRL_IN_USE_BIT] = in_use;
        reg_write(ADDR_CAM_DATA0, REG_DATA_BITS'(key));
        reg_write(ADDR_CAM_DATA1, REG_DATA_BITS'(value));
        reg_write(ADDR_CAM_ENTRY_ID, REG_DATA_BITS'(slot));
        reg_write(ADDR_CAM_CTRL, ctrl);
        // software poll until WR self-clears
        do begin
            reg_read(ADDR_CAM_CTRL, ctrl_expect(cycle + 1), data);
        end while (data[CTRL_WR_BIT]);
        model[slot].in_use = in_use;
        model[slot].key    = key;
        model[slot].value  = value;
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence

    task automatic reset_state();
        logic [REG_DATA_BITS-1:0] data;
        reg_read(ADDR_CAM_LOOKUP_COUNT, '0, data);
        reg_read(ADDR_CAM_HIT_COUNT, '0, data);
        reg_read(ADDR_CAM_MISS_COUNT, '0, data);
        for (int i = 0; i < 4; i++) begin
            lookup(cam_key_t'(rand_bits(KEY_BITS)));
        end
    endtask

    task automatic write_and_hit();
        for (int i = 0; i < PROG_ENTRIES; i++) begin
            // one slot per group of four keeps the slots distinct
            slots[i] = i * 4 + int'(rand_bits(2));
            program_entry(slots[i], cam_key_t'(rand_bits(KEY_BITS)),
                          cam_value_t'(rand_bits(VALUE_BITS)), 1'b1);
        end
        for (int i = 0; i < PROG_ENTRIES; i++) begin
            lookup(model[slots[i]].key);
        end
    endtask

    task automatic miss_and_in_use();
        cam_key_t   key;
        logic       hit;
        cam_value_t value;
        for (int i = 0; i < MISS_KEYS; i++) begin
            do begin
                key = cam_key_t'(rand_bits(KEY_BITS));
                model_lookup(key, hit, value);
            end while (hit);
            lookup(key);
        end
        program_entry(slots[0], model[slots[0]].key, model[slots[0]].value, 1'b0);
        lookup(model[slots[0]].key);
    endtask

    task automatic pipeline_and_priority();
        cam_key_t key;
        for (int i = 0; i < PIPE_LOOKUPS; i++) begin
            if (rand_bits(1) == 1) begin
                key = model[slots[rand_bits(3)]].key;
            end else begin
                key = cam_key_t'(rand_bits(KEY_BITS));
            end
            lookup(key);
        end
        // same key in two slots, the lower one must win
        key = cam_key_t'(rand_bits(KEY_BITS));
        program_entry(30, key, cam_value_t'(rand_bits(VALUE_BITS)), 1'b1);
        lookup(key);
        program_entry(29, key, cam_value_t'(rand_bits(VALUE_BITS)), 1'b1);
        lookup(key);
    endtask

    task automatic counter_readout();
        logic [REG_DATA_BITS-1:0] data;
        logic [REG_DATA_BITS-1:0] clear;
        idle(4);
        reg_read(ADDR_CAM_LOOKUP_COUNT, model_hits + model_misses, data);
        reg_read(ADDR_CAM_HIT_COUNT, model_hits, data);
        reg_read(ADDR_CAM_MISS_COUNT, model_misses, data);
        clear               = '0;
        clear[CTRL_RST_BIT] = 1'b1;
        reg_write(ADDR_CAM_CTRL, clear);
        idle(1);
        reg_read(ADDR_CAM_LOOKUP_COUNT, '0, data);
        reg_read(ADDR_CAM_HIT_COUNT, '0, data);
        reg_read(ADDR_CAM_MISS_COUNT, '0, data);
    endtask

    task automatic entry_read_back();
        logic [REG_DATA_BITS-1:0] ctrl;
        logic [REG_DATA_BITS-1:0] data;
        ctrl              = '0;
        ctrl[CTRL_RD_BIT] = 1'b1;
        for (int i = 0; i < PROG_ENTRIES; i++) begin
            reg_write(ADDR_CAM_ENTRY_ID, REG_DATA_BITS'(slots[i]));
            reg_write(ADDR_CAM_CTRL, ctrl);
            model_ctrl_in_use = model[slots[i]].in_use;
            idle(1);
            reg_read(ADDR_CAM_DATA0, REG_DATA_BITS'(model[slots[i]].key), data);
            reg_read(ADDR_CAM_DATA1, REG_DATA_BITS'(model[slots[i]].value), data);
            reg_read(ADDR_CAM_CTRL, ctrl_expect(cycle + 1), data);
        end
    endtask

    initial begin
        lfsr              = 16'd38;
        reg_wr            = 1'b0;
        reg_rd            = 1'b0;
        reg_addr          = '0;
        reg_wdata         = '0;
        lookup_req        = 1'b0;
        lookup_key        = '0;
        model_hits        = '0;
        model_misses      = '0;
        model_ctrl_in_use = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            model[i] = '0;
        end
        @(posedge rst_n);
        reset_state();
        write_and_hit();
        miss_and_in_use();
        pipeline_and_priority();
        counter_readout();
        entry_read_back();
        idle(4);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: src.f
design/bcam_pkg.sv
design/bcam_reg_decode.sv
design/bcam_entry_store.sv
design/bcam_lookup_result.sv
design/bcam_top.sv
sim/bcam_clk_gen.sv
sim/bcam_tb.sv

// File: Makefile
SOURCES := $(shell cat src.f)

obj_dir/Vbcam_tb: src.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		--top-module bcam_tb -f src.f

.PHONY: run clean

run: obj_dir/Vbcam_tb
	@out="$$(./obj_dir/Vbcam_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
